// File: bench/gb_core_asserts.sv
module gb_core_asserts import gb_pkg::*; (
  input logic    clk,
  input logic    resetn,
  input gb_bus_t bus,
  input logic    halted
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0; // failed assertion count

  no_write_halted: assert property (@(posedge clk) disable iff (!resetn)
    halted |-> !bus.write)
    else begin
      fail_count++;
      $error("bus.write high while halted");
    end

  addr_still_halted: assert property (@(posedge clk) disable iff (!resetn)
    halted |=> $stable(bus.addr))
    else begin
      fail_count++;
      $error("bus.addr moved while halted");
    end

  no_write_after_reset: assert property (@(posedge clk)
    $rose(resetn) |-> !bus.write)
    else begin
      fail_count++;
      $error("bus.write high on first cycle after reset");
    end

endmodule

bind gb_core gb_core_asserts asserts_inst (
  .clk    (clk),
  .resetn (resetn),
  .bus    (bus),
  .halted (halted)
);

// File: bench/gb_core_tb.sv
`include "gb_cfg.svh"

module gb_core_tb import gb_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_progs = 6;
  localparam int n_instr = 110;
  localparam int cycle_limit = n_progs * 130 * 4 + n_progs * 20;

  logic                  clk;
  logic                  resetn;
  logic [`GB_DATA_W-1:0] din;
  gb_bus_t               bus;
  logic                  halted;

  logic [7:0] mem [1024];   // memory seen by the DUT
  logic [7:0] m_mem [1024]; // model copy
  logic [7:0] m_reg [8];
  gb_flags_t  mf;
  logic [15:0] m_pc;
  logic [9:0]  gpc;          // generator write pointer
  gb_bus_t    exp_q [$];
  logic [7:0] dut_w [$];     // data of every DUT write in order
  logic [2:0] dst_set [6] = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd5, 3'd7}; // h stays on data page
  int         err_val;
  int         err_other;
  int         cycles = 0;
  int         wcount;

  assign din = mem[bus.addr[9:0]]; // combinational read

  gb_core gb_core_inst (
    .clk    (clk),
    .resetn (resetn),
    .din    (din),
    .bus    (bus),
    .halted (halted)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(negedge clk) cycles <= cycles + 1;

  initial begin
    wait (cycles > cycle_limit);
    $display("cycle limit %0d reached before halted rose", cycle_limit);
    $display("Finished with errors");
    $finish;
  end

  function automatic int rnd(int n);
    return int'($urandom_range(n - 1, 0));
  endfunction

  task automatic put(input logic [7:0] b);
    mem[gpc]   = b;
    m_mem[gpc] = b;
    gpc        = gpc + 10'd1;
  endtask

  // one-byte stores for a jump to skip
  task automatic plant(input int k);
    logic [2:0] s;
    for (int i = 0; i < k; i++) begin
      s = 3'(rnd(8));
      if (s == 3'd6) s = 3'd7;
      put({5'b01110, s});
    end
  endtask

  task automatic gen_one();
    logic [2:0]  d;
    logic [2:0]  s;
    logic [2:0]  op;
    logic [2:0]  m;
    logic [1:0]  cc;
    logic [15:0] t;
    int          k;
    d  = dst_set[rnd(6)];
    s  = 3'(rnd(8));
    if (s == 3'd6) s = 3'd7;
    op = 3'(rnd(8));
    cc = 2'(rnd(4));
    k  = 1 + rnd(3);
    case (rnd(12))
      0: put(8'h00);
      1: put({2'b01, d, s});
      2: begin
        put({2'b00, d, 3'b110});
        put(8'(rnd(256)));
      end
      3: put({2'b01, d, 3'b110});
      4: put({5'b01110, s});
      5: put({2'b10, op, s});
      6: put({2'b10, op, 3'b110});
      7: begin
        put({2'b11, op, 3'b110});
        put(8'(rnd(256)));
      end
      8: put({2'b00, d, 2'b10, 1'(rnd(2))}); // inc or dec
      9: begin
        m = 3'(rnd(7));
        if (m == 3'd4) m = 3'd7; // no daa
        put({2'b00, m, 3'b111});
      end
      10: begin
        if (rnd(2) == 0) put(8'h18);
        else put({3'b001, cc, 3'b000});
        put(8'(k));
        plant(k);
      end
      default: begin
        t = 16'({6'd0, gpc}) + 16'd3 + 16'(k);
        if (rnd(2) == 0) put(8'hc3);
        else put({3'b110, cc, 3'b010});
        put(t[7:0]);
        put(t[15:8]);
        plant(k);
      end
    endcase
  endtask

  task automatic build_program();
    int n;
    for (int a = 0; a < 1024; a++) begin
      mem[a]   = 8'((a * 37) ^ (a >> 8));
      m_mem[a] = mem[a];
    end
    exp_q.delete();
    dut_w.delete();
    gpc = '0;
    put(8'h26); // ld h,03
    put(8'h03);
    put(8'h2e);
    put(8'(rnd(256)));
    n = 0;
    while (n < n_instr && gpc < 10'h2c0) begin
      gen_one();
      n++;
    end
    // b ends at 1 on z and c at 1 on carry
    put(8'h06);
    put(8'h00);
    put(8'h20); // jr nz,+2
    put(8'h02);
    put(8'h06);
    put(8'h01);
    put(8'h0e);
    put(8'h00);
    put(8'h30); // jr nc,+2
    put(8'h02);
    put(8'h0e);
    put(8'h01);
    for (int r = 0; r < 8; r++) begin
      if (r != 6) put(8'h70 | 8'(r));
    end
    put(8'h76);
  endtask

  function automatic logic cond_ok(input logic [1:0] cc);
    case (cc)
      2'd0: return !mf.z;
      2'd1: return mf.z;
      2'd2: return !mf.c;
      default: return mf.c;
    endcase
  endfunction

  task automatic model_alu(input logic [2:0] op, input logic [7:0] b);
    int         ai;
    int         bi;
    int         ci;
    int         ri;
    logic [7:0] res;
    ai = int'(m_reg[7]);
    bi = int'(b);
    ci = (op == 3'd1 || op == 3'd3) ? int'(mf.c) : 0;
    case (op)
      3'd0, 3'd1: begin
        ri   = ai + bi + ci;
        mf.n = 1'b0;
        mf.h = ((ai & 15) + (bi & 15) + ci) > 15;
        mf.c = ri > 255;
      end
      3'd4: begin
        ri   = ai & bi;
        mf.n = 1'b0;
        mf.h = 1'b1;
        mf.c = 1'b0;
      end
      3'd5: begin
        ri   = ai ^ bi;
        mf.n = 1'b0;
        mf.h = 1'b0;
        mf.c = 1'b0;
      end
      3'd6: begin
        ri   = ai | bi;
        mf.n = 1'b0;
        mf.h = 1'b0;
        mf.c = 1'b0;
      end
      default: begin // sub, sbc, cp
        ri   = ai - bi - ci;
        mf.n = 1'b1;
        mf.h = (ai & 15) < ((bi & 15) + ci);
        mf.c = ai < (bi + ci);
      end
    endcase
    res  = 8'(ri);
    mf.z = (res == 8'h00);
    if (op != 3'd7) m_reg[7] = res; // cp keeps a
  endtask

  task automatic model_misc(input logic [2:0] m);
    logic [7:0] a;
    a = m_reg[7];
    case (m)
      3'd0: begin
        m_reg[7] = {a[6:0], a[7]};
        mf       = {3'b000, a[7]};
      end
      3'd1: begin
        m_reg[7] = {a[0], a[7:1]};
        mf       = {3'b000, a[0]};
      end
      3'd2: begin
        m_reg[7] = {a[6:0], mf.c};
        mf       = {3'b000, a[7]};
      end
      3'd3: begin
        m_reg[7] = {mf.c, a[7:1]};
        mf       = {3'b000, a[0]};
      end
      3'd5: begin
        m_reg[7] = ~a;
        mf.n     = 1'b1;
        mf.h     = 1'b1;
      end
      3'd6: begin
        mf.n = 1'b0;
        mf.h = 1'b0;
        mf.c = 1'b1;
      end
      3'd7: begin
        mf.n = 1'b0;
        mf.h = 1'b0;
        mf.c = ~mf.c;
      end
      default: ;
    endcase
  endtask

  task automatic execute_step(output logic halt);
    logic [7:0]  op;
    logic [7:0]  v;
    logic [7:0]  lo;
    logic [15:0] hl;
    logic [2:0]  d;
    logic [2:0]  s;
    gb_bus_t     e;
    op   = m_mem[m_pc[9:0]];
    m_pc = m_pc + 16'd1;
    d    = op[5:3];
    s    = op[2:0];
    hl   = {m_reg[4], m_reg[5]};
    halt = 1'b0;
    if (op == 8'h76) begin
      halt = 1'b1;
    end else if (op[7:6] == 2'b01) begin
      if (s == 3'd6) begin
        m_reg[d] = m_mem[hl[9:0]];
      end else if (d == 3'd6) begin
        e.addr = hl;
        e.dout = m_reg[s];
        e.write = 1'b1;
        exp_q.push_back(e);
        m_mem[hl[9:0]] = m_reg[s];
      end else begin
        m_reg[d] = m_reg[s];
      end
    end else if (op[7:6] == 2'b10) begin
      model_alu(d, (s == 3'd6) ? m_mem[hl[9:0]] : m_reg[s]);
    end else if (op[7:6] == 2'b11) begin
      v = m_mem[m_pc[9:0]];
      if (s == 3'd6) begin
        m_pc = m_pc + 16'd1;
        model_alu(d, v);
      end else if (op == 8'hc3 || (op[5] == 1'b0 && s == 3'd2)) begin
        lo   = v;
        v    = m_mem[m_pc[9:0] + 10'd1];
        m_pc = m_pc + 16'd2;
        if (op == 8'hc3 || cond_ok(op[4:3])) m_pc = {v, lo};
      end
    end else begin
      v = m_mem[m_pc[9:0]];
      case (s)
        3'd6: begin
          m_reg[d] = v;
          m_pc     = m_pc + 16'd1;
        end
        3'd4, 3'd5: begin
          lo       = m_reg[d];
          m_reg[d] = s[0] ? lo - 8'd1 : lo + 8'd1;
          mf.z     = (m_reg[d] == 8'h00);
          mf.n     = s[0];
          mf.h     = s[0] ? (lo[3:0] == 4'h0) : (lo[3:0] == 4'hf);
        end
        3'd7: model_misc(d);
        3'd0: begin
          if (op == 8'h18 || op[7:5] == 3'b001) begin
            m_pc = m_pc + 16'd1;
            if (op == 8'h18 || cond_ok(op[4:3])) m_pc = m_pc + {{8{v[7]}}, v};
          end
        end
        default: ;
      endcase
    end
  endtask

  task automatic run_model();
    logic halt;
    int   steps;
    for (int r = 0; r < 8; r++) m_reg[r] = 8'h00;
    mf    = '0;
    m_pc  = `GB_RESET_PC;
    halt  = 1'b0;
    steps = 0;
    while (!halt && steps < 4000) begin
      execute_step(halt);
      steps++;
    end
  endtask

  task automatic check_bus(input string name, input gb_bus_t exp, input gb_bus_t act);
    if (exp !== act) begin
      $display("ERR %s expected addr=%h dout=%h write=%b actual addr=%h dout=%h write=%b",
               name, exp.addr, exp.dout, exp.write, act.addr, act.dout, act.write);
      err_val++;
    end
  endtask

  task automatic check_flags(input string name, input gb_flags_t exp, input gb_flags_t act);
    if (exp !== act) begin
      $display("ERR %s expected flags=%b actual flags=%b", name, exp, act);
      err_val++;
    end
  endtask

  task automatic handle_write(input int p);
    gb_bus_t e;
    if (exp_q.size() == 0) begin
      $display("prog %0d: DUT wrote %h to %h where the model has no write left",
               p, bus.dout, bus.addr);
      err_other++;
    end else begin
      e = exp_q.pop_front();
      check_bus($sformatf("prog%0d write%0d", p, wcount), e, bus);
    end
    mem[bus.addr[9:0]] = bus.dout;
    dut_w.push_back(bus.dout);
    wcount++;
  endtask

  task automatic run_dut(input int p);
    gb_flags_t act;
    wcount = 0;
    while (!halted) begin
      @(negedge clk);
      if (bus.write) handle_write(p);
    end
    repeat (4) begin
      @(negedge clk);
      if (bus.write) begin
        $display("prog %0d: write seen after halt", p);
        err_other++;
      end
    end
    if (exp_q.size() != 0) begin
      $display("prog %0d: %0d expected writes never happened", p, exp_q.size());
      err_other++;
    end
    if (dut_w.size() >= 7) begin
      act = {dut_w[dut_w.size() - 7] == 8'h01, 2'b00, dut_w[dut_w.size() - 6] == 8'h01};
      check_flags($sformatf("prog%0d flags", p), {mf.z, 2'b00, mf.c}, act);
    end else begin
      $display("prog %0d: too few writes to read back the flags", p);
      err_other++;
    end
  endtask

  initial begin
    resetn    = 1'b0;
    err_val   = 0;
    err_other = 0;
    void'($urandom(32'h9fd3));
    for (int p = 0; p < n_progs; p++) begin
      @(posedge clk);
      resetn <= 1'b0;
      build_program();
      run_model();
      repeat (8) @(posedge clk);
      resetn <= 1'b1;
      run_dut(p);
    end
    $display("value errors: %0d, other errors: %0d, assertion failures: %0d",
             err_val, err_other, gb_core_inst.asserts_inst.fail_count);
    if (err_val == 0 && err_other == 0 && gb_core_inst.asserts_inst.fail_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: rtl/gb_alu.sv
`include "gb_cfg.svh"

module gb_alu import gb_pkg::*; (
  input  gb_ctrl_t              ctrl,
  input  logic [`GB_DATA_W-1:0] acc,
  input  logic [`GB_DATA_W-1:0] operand,
  input  gb_flags_t             flags_in,
  output logic [`GB_DATA_W-1:0] result,
  output gb_flags_t             flags_out
);

  logic       carry_in;
  logic [8:0] sum;
  logic [8:0] diff;
  logic [4:0] sum_h;
  logic [4:0] diff_h;
  logic [7:0] inc_dec;

  assign carry_in = (ctrl.alu == `GB_ALU_ADC || ctrl.alu == `GB_ALU_SBC) && flags_in.c;
  assign sum      = {1'b0, acc} + {1'b0, operand} + {8'd0, carry_in};
  assign sum_h    = {1'b0, acc[3:0]} + {1'b0, operand[3:0]} + {4'd0, carry_in};
  assign diff     = {1'b0, acc} - {1'b0, operand} - {8'd0, carry_in};
  assign diff_h   = {1'b0, acc[3:0]} - {1'b0, operand[3:0]} - {4'd0, carry_in};
  assign inc_dec  = ctrl.src[0] ? operand - 8'd1 : operand + 8'd1; // src bit 0 set for dec

  always_comb begin
    result    = acc;
    flags_out = flags_in;
    case (ctrl.kind)
      k_incdec: begin
        result      = inc_dec;
        flags_out.z = (inc_dec == 8'h00);
        flags_out.n = ctrl.src[0];
        flags_out.h = ctrl.src[0] ? (operand[3:0] == 4'h0) : (operand[3:0] == 4'hf);
      end
      k_acc_misc: begin
        case (ctrl.alu)
          `GB_MISC_RLCA: begin result = {acc[6:0], acc[7]}; flags_out = {3'b000, acc[7]}; end
          `GB_MISC_RRCA: begin result = {acc[0], acc[7:1]}; flags_out = {3'b000, acc[0]}; end
          `GB_MISC_RLA: begin result = {acc[6:0], flags_in.c}; flags_out = {3'b000, acc[7]}; end
          `GB_MISC_RRA: begin result = {flags_in.c, acc[7:1]}; flags_out = {3'b000, acc[0]}; end
          `GB_MISC_CPL: begin result = ~acc; flags_out.n = 1'b1; flags_out.h = 1'b1; end
          `GB_MISC_SCF: begin flags_out.n = 1'b0; flags_out.h = 1'b0; flags_out.c = 1'b1; end
          `GB_MISC_CCF: begin flags_out.n = 1'b0; flags_out.h = 1'b0; flags_out.c = ~flags_in.c; end
          default: ;
        endcase
      end
      default: begin
        case (ctrl.alu)
          `GB_ALU_ADD, `GB_ALU_ADC: begin
            result    = sum[7:0];
            flags_out = {sum[7:0] == 8'h00, 1'b0, sum_h[4], sum[8]};
          end
          `GB_ALU_SUB, `GB_ALU_SBC: begin
            result    = diff[7:0];
            flags_out = {diff[7:0] == 8'h00, 1'b1, diff_h[4], diff[8]};
          end
          `GB_ALU_AND: begin
            result    = acc & operand;
            flags_out = {(acc & operand) == 8'h00, 1'b0, 1'b1, 1'b0};
          end
          `GB_ALU_XOR: begin
            result    = acc ^ operand;
            flags_out = {(acc ^ operand) == 8'h00, 3'b000};
          end
          `GB_ALU_OR: begin
            result    = acc | operand;
            flags_out = {(acc | operand) == 8'h00, 3'b000};
          end
          default: flags_out = {diff[7:0] == 8'h00, 1'b1, diff_h[4], diff[8]}; // cp, a kept
        endcase
      end
    endcase
  end

endmodule

// File: rtl/gb_cfg.svh
`ifndef GB_CFG_SVH
`define GB_CFG_SVH

`define GB_ADDR_W 16
`define GB_DATA_W 8
`define GB_RESET_PC 16'h0000

// accumulator ops, opcode bits 5:3
`define GB_ALU_ADD 3'd0
`define GB_ALU_ADC 3'd1
`define GB_ALU_SUB 3'd2
`define GB_ALU_SBC 3'd3
`define GB_ALU_AND 3'd4
`define GB_ALU_XOR 3'd5
`define GB_ALU_OR 3'd6
`define GB_ALU_CP 3'd7

// misc accumulator group, opcode bits 5:3 of 8'b00xxx111
`define GB_MISC_RLCA 3'd0
`define GB_MISC_RRCA 3'd1
`define GB_MISC_RLA 3'd2
`define GB_MISC_RRA 3'd3
`define GB_MISC_CPL 3'd5
`define GB_MISC_SCF 3'd6
`define GB_MISC_CCF 3'd7

`define GB_REG_H 3'd4
`define GB_REG_L 3'd5
`define GB_REG_MEM 3'd6 // (hl) slot
`define GB_REG_A 3'd7

`define GB_OP_HALT 8'h76
`define GB_OP_JP 8'hc3
`define GB_OP_JR 8'h18

`endif

// File: rtl/gb_core.sv
`include "gb_cfg.svh"

module gb_core import gb_pkg::*; (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic [`GB_DATA_W-1:0] din,
  output gb_bus_t               bus,
  output logic                  halted
);

  gb_ctrl_t              ctrl;
  gb_flags_t             flags;
  gb_flags_t             alu_flags;
  gb_flags_t             flags_wr;
  logic [`GB_DATA_W-1:0] opcode;
  logic [`GB_DATA_W-1:0] rd_a;
  logic [`GB_DATA_W-1:0] rd_b;
  logic [`GB_DATA_W-1:0] acc;
  logic [`GB_DATA_W-1:0] operand;
  logic [`GB_DATA_W-1:0] alu_result;
  logic [`GB_DATA_W-1:0] wr_data;
  logic [`GB_ADDR_W-1:0] hl;
  logic [2:0]            rd_a_idx;
  logic [2:0]            rd_b_idx;
  logic [2:0]            wr_idx;
  logic                  wr_en;
  logic                  flags_en;

  gb_sequencer sequencer_inst (
    .clk        (clk),
    .resetn     (resetn),
    .din        (din),
    .ctrl_in    (ctrl),
    .opcode     (opcode),
    .rd_a_idx   (rd_a_idx),
    .rd_b_idx   (rd_b_idx),
    .rd_a       (rd_a),
    .rd_b       (rd_b),
    .hl         (hl),
    .flags      (flags),
    .alu_result (alu_result),
    .alu_flags  (alu_flags),
    .operand    (operand),
    .wr_en      (wr_en),
    .wr_idx     (wr_idx),
    .wr_data    (wr_data),
    .flags_en   (flags_en),
    .flags_in   (flags_wr),
    .bus        (bus),
    .halted     (halted)
  );

  gb_decode decode_inst (
    .opcode (opcode),
    .ctrl   (ctrl)
  );

  gb_regfile regfile_inst (
    .clk      (clk),
    .resetn   (resetn),
    .rd_a_idx (rd_a_idx),
    .rd_b_idx (rd_b_idx),
    .rd_a     (rd_a),
    .rd_b     (rd_b),
    .acc      (acc),
    .hl       (hl),
    .flags    (flags),
    .wr_en    (wr_en),
    .wr_idx   (wr_idx),
    .wr_data  (wr_data),
    .flags_en (flags_en),
    .flags_in (flags_wr)
  );

  gb_alu alu_inst (
    .ctrl      (ctrl),
    .acc       (acc),
    .operand   (operand),
    .flags_in  (flags),
    .result    (alu_result),
    .flags_out (alu_flags)
  );

endmodule

// File: rtl/gb_decode.sv
`include "gb_cfg.svh"

module gb_decode import gb_pkg::*; (
  input  logic [`GB_DATA_W-1:0] opcode,
  output gb_ctrl_t              ctrl
);

  always_comb begin
    // operand fields come straight from the opcode bits
    ctrl.kind = k_nop;
    ctrl.dst  = opcode[5:3];
    ctrl.src  = opcode[2:0];
    ctrl.alu  = opcode[5:3];
    ctrl.cc   = opcode[4:3];
    ctrl.cond = 1'b0;
    casez (opcode)
      8'h07, 8'h0f, 8'h17, 8'h1f, 8'h2f, 8'h37, 8'h3f: begin
        ctrl.kind = k_acc_misc;
      end
      8'b110??010: begin // jp cc,a16
        ctrl.kind = k_jp;
        ctrl.cond = 1'b1;
      end
      `GB_OP_JP: begin
        ctrl.kind = k_jp;
      end
      `GB_OP_HALT: begin
        ctrl.kind = k_halt; // ahead of the 01xxxxxx forms
      end
      8'b01110???: begin
        ctrl.kind = k_st_mem;
      end
      8'b01???110: begin
        ctrl.kind = k_ld_mem;
      end
      8'h34, 8'h35, 8'h36: begin
        ctrl.kind = k_nop; // (hl) read-modify-write forms not kept
      end
      8'b00???110: begin
        ctrl.kind = k_ld_imm;
      end
      8'b00???10?: begin
        ctrl.kind = k_incdec;
      end
      8'b01??????: begin
        ctrl.kind = k_ld_rr;
      end
      8'b10???110: begin
        ctrl.kind = k_alu_mem;
      end
      8'b10??????: begin
        ctrl.kind = k_alu_r;
      end
      8'b11???110: begin
        ctrl.kind = k_alu_imm;
      end
      `GB_OP_JR: begin
        ctrl.kind = k_jr;
      end
      8'b001??000: begin // jr cc,d8
        ctrl.kind = k_jr;
        ctrl.cond = 1'b1;
      end
      default: ctrl.kind = k_nop; // undefined or dropped
    endcase
  end

endmodule

// File: rtl/gb_pkg.sv
`include "gb_cfg.svh"

package gb_pkg;

  typedef struct packed {
    logic [`GB_ADDR_W-1:0] addr;
    logic [`GB_DATA_W-1:0] dout;
    logic                  write;
  } gb_bus_t;

  typedef struct packed {
    logic z;
    logic n;
    logic h;
    logic c;
  } gb_flags_t;

  typedef enum logic [3:0] {
    k_nop,
    k_ld_rr,
    k_ld_imm,
    k_ld_mem,   // ld r,(hl)
    k_st_mem,   // ld (hl),r
    k_alu_r,
    k_alu_mem,
    k_alu_imm,
    k_incdec,
    k_acc_misc, // rotates, cpl, scf, ccf
    k_jp,
    k_jr,
    k_halt
  } gb_kind_t;

  typedef struct packed {
    gb_kind_t   kind;
    logic [2:0] dst;
    logic [2:0] src;
    logic [2:0] alu;
    logic [1:0] cc;   // nz, z, nc, c
    logic       cond; // jump tests cc
  } gb_ctrl_t;

  typedef enum logic [2:0] {
    s_f0,
    s_f1,
    s_f2,
    s_wa,
    s_w1
  } gb_state_t;

endpackage

// File: rtl/gb_regfile.sv
`include "gb_cfg.svh"

module gb_regfile import gb_pkg::*; (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic [2:0]            rd_a_idx,
  input  logic [2:0]            rd_b_idx,
  output logic [`GB_DATA_W-1:0] rd_a,
  output logic [`GB_DATA_W-1:0] rd_b,
  output logic [`GB_DATA_W-1:0] acc,
  output logic [`GB_ADDR_W-1:0] hl,
  output gb_flags_t             flags,
  input  logic                  wr_en,
  input  logic [2:0]            wr_idx,
  input  logic [`GB_DATA_W-1:0] wr_data,
  input  logic                  flags_en,
  input  gb_flags_t             flags_in
);

  // b c d e h l - a, slot 6 unused
  logic [`GB_DATA_W-1:0] regs [8];

  assign rd_a = (rd_a_idx == `GB_REG_MEM) ? '0 : regs[rd_a_idx];
  assign rd_b = (rd_b_idx == `GB_REG_MEM) ? '0 : regs[rd_b_idx];
  assign acc  = regs[`GB_REG_A];
  assign hl   = {regs[`GB_REG_H], regs[`GB_REG_L]};

  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
      flags <= '0;
    end else begin
      if (wr_en && wr_idx != `GB_REG_MEM) begin
        regs[wr_idx] <= wr_data;
      end
      if (flags_en) begin
        flags <= flags_in;
      end
    end
  end

endmodule

// File: rtl/gb_sequencer.sv
`include "gb_cfg.svh"

module gb_sequencer import gb_pkg::*; (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic [`GB_DATA_W-1:0] din,
  input  gb_ctrl_t              ctrl_in,
  output logic [`GB_DATA_W-1:0] opcode,
  output logic [2:0]            rd_a_idx,
  output logic [2:0]            rd_b_idx,
  input  logic [`GB_DATA_W-1:0] rd_a,
  input  logic [`GB_DATA_W-1:0] rd_b,
  input  logic [`GB_ADDR_W-1:0] hl,
  input  gb_flags_t             flags,
  input  logic [`GB_DATA_W-1:0] alu_result,
  input  gb_flags_t             alu_flags,
  output logic [`GB_DATA_W-1:0] operand,
  output logic                  wr_en,
  output logic [2:0]            wr_idx,
  output logic [`GB_DATA_W-1:0] wr_data,
  output logic                  flags_en,
  output gb_flags_t             flags_in,
  output gb_bus_t               bus,
  output logic                  halted
);

  gb_state_t             state;
  logic [`GB_ADDR_W-1:0] pc;
  logic [`GB_ADDR_W-1:0] pc_inc;
  logic [`GB_ADDR_W-1:0] jr_target;
  logic [`GB_DATA_W-1:0] op_q;  // opcode held past f0
  logic [`GB_DATA_W-1:0] jp_lo; // low byte of jp target
  logic                  cc_ok;
  logic                  taken;
  logic                  exec_f0;
  logic                  exec_f1;

  // decode re-runs on the held opcode, so ctrl_in stays valid in later states
  assign opcode    = (state == s_f0) ? din : op_q;
  assign rd_a_idx  = ctrl_in.dst;
  assign rd_b_idx  = ctrl_in.src;
  assign pc_inc    = pc + 16'd1;
  assign jr_target = pc_inc + {{8{din[7]}}, din}; // pc sits on the d8 byte
  assign exec_f0   = (state == s_f0) && !halted;
  assign exec_f1   = (state == s_f1);
  assign flags_in  = alu_flags;

  always_comb begin
    case (ctrl_in.cc)
      2'd0:    cc_ok = !flags.z;
      2'd1:    cc_ok = flags.z;
      2'd2:    cc_ok = !flags.c;
      default: cc_ok = flags.c;
    endcase
  end
  assign taken = !ctrl_in.cond || cc_ok;

  always_comb begin
    case (ctrl_in.kind)
      k_incdec: operand = rd_a;
      k_alu_r:  operand = rd_b;
      default:  operand = din; // d8 or (hl) data
    endcase
  end

  always_comb begin
    wr_en    = 1'b0;
    flags_en = 1'b0;
    wr_idx   = ctrl_in.dst;
    wr_data  = alu_result;
    case (ctrl_in.kind)
      k_ld_rr: begin
        wr_en   = exec_f0;
        wr_data = rd_b;
      end
      k_incdec: begin
        wr_en    = exec_f0;
        flags_en = exec_f0;
      end
      k_alu_r, k_acc_misc: begin
        wr_en    = exec_f0;
        flags_en = exec_f0;
        wr_idx   = `GB_REG_A;
      end
      k_ld_imm, k_ld_mem: begin
        wr_en   = exec_f1;
        wr_data = din;
      end
      k_alu_mem, k_alu_imm: begin
        wr_en    = exec_f1;
        flags_en = exec_f1;
        wr_idx   = `GB_REG_A;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= s_f0;
      pc        <= `GB_RESET_PC;
      bus.addr  <= `GB_RESET_PC;
      bus.write <= 1'b0;
      halted    <= 1'b0;
    end else begin
      case (state)
        s_f0: begin
          if (!halted) begin
            op_q     <= din;
            pc       <= pc_inc;
            bus.addr <= pc_inc;
            case (ctrl_in.kind)
              k_ld_imm, k_alu_imm, k_jr: state <= s_f1;
              k_jp: state <= s_f2;
              k_ld_mem, k_alu_mem: begin
                state    <= s_f1;
                bus.addr <= hl;
              end
              k_st_mem: begin
                state     <= s_w1;
                bus.addr  <= hl;
                bus.dout  <= rd_b;
                bus.write <= 1'b1;
              end
              k_halt: halted <= 1'b1;
              default: ;
            endcase
          end
        end
        s_f2: begin
          jp_lo    <= din;
          pc       <= pc_inc;
          bus.addr <= pc_inc;
          state    <= s_f1;
        end
        s_f1: begin
          if (ctrl_in.kind == k_ld_mem || ctrl_in.kind == k_alu_mem) begin
            bus.addr <= pc; // park on the next opcode
            state    <= s_wa;
          end else if (ctrl_in.kind == k_jr && taken) begin
            pc       <= jr_target;
            bus.addr <= jr_target;
            state    <= s_wa;
          end else if (ctrl_in.kind == k_jp && taken) begin
            pc       <= {din, jp_lo};
            bus.addr <= {din, jp_lo};
            state    <= s_wa;
          end else begin
            pc       <= pc_inc; // d8 done or branch not taken
            bus.addr <= pc_inc;
            state    <= s_f0;
          end
        end
        s_w1: begin
          bus.write <= 1'b0;
          bus.addr  <= pc;
          state     <= s_wa;
        end
        default: state <= s_f0; // s_wa
      endcase
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the gb_core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module gb_core_tb -o gb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/gb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Finished with no errors" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

// File: sim.f
+incdir+rtl
rtl/gb_pkg.sv
rtl/gb_alu.sv
rtl/gb_decode.sv
rtl/gb_regfile.sv
rtl/gb_sequencer.sv
rtl/gb_core.sv
bench/gb_core_asserts.sv
bench/gb_core_tb.sv
